//--- dv/tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic failNow(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic checkValue(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
        failNow($sformatf("FAILED %s: expected %h actual %h", name, expected, actual));
    end
endtask

task automatic newProgram();
    progLen = 0;
    for (int i = 0; i < 64; i++) begin
        memModel[i[5:0]] = '0;
    end
    for (int i = 0; i < 32; i++) begin
        expValid[i[4:0]] = 1'b0;
    end
endtask

task automatic emit(input logic [31:0] w);
    prog[progLen[5:0]] = w;
    progLen++;
endtask

task automatic expectReg(input int rd, input logic [63:0] val);
    expRegs[rd[4:0]]  = val;
    expValid[rd[4:0]] = 1'b1;
endtask

// lui + addiw gives the sign-extended 32-bit value
task automatic loadConst(input int rd, input int val);
    int hi;
    hi = (val + 32'h800) >> 12;
    emit(encU(hi, rd, `OP_LUI));
    emit(encI(val, rd, `F3_ADD, rd, `OP_IMM32));
endtask

task automatic rType(input logic [6:0] f7, input logic [2:0] f3, input int rs1, input int rs2,
                     input int rd, input logic [6:0] op, input logic [63:0] val);
    emit(encR(f7, rs2, rs1, f3, rd, op));
    expectReg(rd, val);
endtask

task automatic iType(input int imm, input logic [2:0] f3, input int rd,
                     input logic [6:0] op, input logic [63:0] val);
    emit(encI(imm, 1, f3, rd, op));
    expectReg(rd, val);
endtask

task automatic storeOp(input int f3, input int rs2, input logic [63:0] val, input int off);
    emit(encS(off, rs2, 1, f3[2:0]));
    for (int k = 0; k < (1 << f3); k++) begin
        memModel[6'(off + k)] = 8'(val >> (8 * k));
    end
endtask

task automatic loadOp(input int f3, input int rd, input int off);
    logic [63:0] v;
    int          nBytes;
    int          s;
    nBytes = 1 << (f3 & 3);
    s      = 64 - 8 * nBytes;
    v      = '0;
    for (int k = nBytes - 1; k >= 0; k--) begin
        v = {v[55:0], memModel[6'(off + k)]};
    end
    if (f3 < 4)
        v = $signed(v << s) >>> s; // lb, lh, lw extend the sign
    emit(encI(off, 1, f3[2:0], rd, `OP_LOAD));
    expectReg(rd, v);
endtask

task automatic runProgram(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    rstN = 1'b0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    while (!halted) begin
        @(negedge clk);
        cycles++;
        if (cycles > 200)
            failNow({"timeout: ", name, " did not reach ebreak within 200 cycles"});
    end
endtask

task automatic verifyRegs(input string name);
    for (int r = 0; r < 32; r++) begin
        if (expValid[r[4:0]]) begin
            @(negedge clk);
            dbgAddr = r[4:0];
            #1;
            checkValue($sformatf("%s x%0d", name, r), expRegs[r[4:0]], dbgData);
        end
    end
endtask

task automatic aluTest();
    int                 ra, rb, imm, sh;
    logic [63:0]        a, b, ix;
    logic signed [31:0] sa;
    ra  = $random(seed) | 32'h8000_0000; // negative, exercises arithmetic shifts
    rb  = $random(seed);
    imm = $random(seed);
    sh  = $random(seed);
    a   = sx(ra);
    b   = sx(rb);
    ix  = sx({{20{imm[11]}}, imm[11:0]});
    sa  = a[31:0];
    newProgram();
    loadConst(1, ra);
    loadConst(2, rb);
    expectReg(1, a);
    expectReg(2, b);
    rType(`F7_BASE, `F3_ADD, 1, 2, 3, `OP_REG, a + b);
    rType(`F7_ALT, `F3_ADD, 1, 2, 4, `OP_REG, a - b);
    rType(`F7_BASE, `F3_SLL, 1, 2, 5, `OP_REG, a << b[5:0]);
    rType(`F7_BASE, `F3_SLT, 1, 2, 6, `OP_REG, {63'b0, $signed(a) < $signed(b)});
    rType(`F7_BASE, `F3_SLTU, 1, 2, 7, `OP_REG, {63'b0, a < b});
    rType(`F7_BASE, `F3_XOR, 1, 2, 8, `OP_REG, a ^ b);
    rType(`F7_BASE, `F3_SR, 1, 2, 9, `OP_REG, a >> b[5:0]);
    rType(`F7_ALT, `F3_SR, 1, 2, 10, `OP_REG, $signed(a) >>> b[5:0]);
    rType(`F7_BASE, `F3_OR, 1, 2, 11, `OP_REG, a | b);
    rType(`F7_BASE, `F3_AND, 1, 2, 12, `OP_REG, a & b);
    rType(`F7_BASE, `F3_ADD, 1, 2, 13, `OP_REG32, sx(a[31:0] + b[31:0]));
    rType(`F7_ALT, `F3_ADD, 1, 2, 14, `OP_REG32, sx(a[31:0] - b[31:0]));
    rType(`F7_BASE, `F3_SLL, 1, 2, 15, `OP_REG32, sx(a[31:0] << b[4:0]));
    rType(`F7_BASE, `F3_SR, 1, 2, 16, `OP_REG32, sx(a[31:0] >> b[4:0]));
    rType(`F7_ALT, `F3_SR, 1, 2, 17, `OP_REG32, sx(sa >>> b[4:0]));
    iType(imm, `F3_ADD, 18, `OP_IMM, a + ix);
    iType(imm, `F3_SLT, 19, `OP_IMM, {63'b0, $signed(a) < $signed(ix)});
    iType(imm, `F3_SLTU, 20, `OP_IMM, {63'b0, a < ix});
    iType(imm, `F3_XOR, 21, `OP_IMM, a ^ ix);
    iType(imm, `F3_OR, 22, `OP_IMM, a | ix);
    iType(imm, `F3_AND, 23, `OP_IMM, a & ix);
    iType(sh & 63, `F3_SLL, 24, `OP_IMM, a << sh[5:0]);
    iType(sh & 63, `F3_SR, 25, `OP_IMM, a >> sh[5:0]);
    iType((sh & 63) | 'h400, `F3_SR, 26, `OP_IMM, $signed(a) >>> sh[5:0]);
    iType(imm, `F3_ADD, 27, `OP_IMM32, sx(a[31:0] + ix[31:0]));
    iType(sh & 31, `F3_SLL, 28, `OP_IMM32, sx(a[31:0] << sh[4:0]));
    iType(sh & 31, `F3_SR, 29, `OP_IMM32, sx(a[31:0] >> sh[4:0]));
    iType((sh & 31) | 'h400, `F3_SR, 30, `OP_IMM32, sx(sa >>> sh[4:0]));
    emit(encU(rb, 31, `OP_LUI));
    expectReg(31, sx({rb[19:0], 12'b0}));
    runProgram("alu");
    verifyRegs("alu");
endtask

task automatic mulDivTest();
    int                 ra, rb;
    logic [63:0]        a, b;
    logic signed [31:0] sa, sb;
    ra = $random(seed);
    rb = $random(seed);
    if (rb == 0 || rb == -1)
        rb = 7; // corner cases get their own program below
    a  = sx(ra);
    b  = sx(rb);
    sa = ra;
    sb = rb;
    newProgram();
    loadConst(1, ra);
    loadConst(2, rb);
    rType(`F7_MULDIV, `F3_MUL, 1, 2, 3, `OP_REG, a * b);
    rType(`F7_MULDIV, `F3_MUL, 1, 2, 4, `OP_REG32, sx(a[31:0] * b[31:0]));
    rType(`F7_MULDIV, `F3_DIV, 1, 2, 5, `OP_REG32, sx(sa / sb));
    rType(`F7_MULDIV, `F3_DIVU, 1, 2, 6, `OP_REG32, sx(a[31:0] / b[31:0]));
    rType(`F7_MULDIV, `F3_REM, 1, 2, 7, `OP_REG32, sx(sa % sb));
    rType(`F7_MULDIV, `F3_REMU, 1, 2, 8, `OP_REG32, sx(a[31:0] % b[31:0]));
    runProgram("muldiv");
    verifyRegs("muldiv");

    // most negative by -1, then everything by zero through x0
    newProgram();
    loadConst(1, 32'h8000_0000);
    loadConst(2, -1);
    rType(`F7_MULDIV, `F3_DIV, 1, 2, 3, `OP_REG32, sx(32'h8000_0000));
    rType(`F7_MULDIV, `F3_REM, 1, 2, 4, `OP_REG32, 0);
    rType(`F7_MULDIV, `F3_DIV, 1, 0, 5, `OP_REG32, {64{1'b1}});
    rType(`F7_MULDIV, `F3_DIVU, 1, 0, 6, `OP_REG32, {64{1'b1}});
    rType(`F7_MULDIV, `F3_REM, 1, 0, 7, `OP_REG32, sx(32'h8000_0000));
    rType(`F7_MULDIV, `F3_REMU, 1, 0, 8, `OP_REG32, sx(32'h8000_0000));
    runProgram("muldiv corner");
    verifyRegs("muldiv corner");
endtask

task automatic memTest();
    int          rd, re;
    logic [63:0] d, e;
    rd = $random(seed) | 32'h8080_8080; // every byte has its sign bit set
    re = $random(seed);
    d  = sx(rd);
    e  = sx(re);
    newProgram();
    emit(encU(0, 1, `OP_AUIPC)); // base = RESET_PC
    expectReg(1, `RESET_PC);
    loadConst(2, rd);
    loadConst(3, re);
    storeOp(3, 2, d, 16);
    storeOp(2, 3, e, 20);
    storeOp(3, 3, e, 24);
    storeOp(1, 2, d, 26);
    storeOp(0, 2, d, 29);
    storeOp(0, 3, e, 31);
    loadOp(3, 4, 16);
    loadOp(2, 5, 20);
    loadOp(6, 6, 20);
    loadOp(1, 7, 26);
    loadOp(5, 8, 26);
    loadOp(0, 9, 29);
    loadOp(4, 10, 31);
    loadOp(0, 11, 31);
    loadOp(3, 12, 24);
    loadOp(2, 13, 16);
    loadOp(5, 14, 22);
    loadOp(4, 15, 17);
    runProgram("load/store");
    verifyRegs("load/store");
endtask

task automatic branchTest();
    int          ia, ib;
    logic [63:0] a, b;
    logic        taken;
    string       name;
    for (int k = 0; k < 8; k++) begin
        if (k == 2 || k == 3)
            continue;
        for (int p = 0; p < 3; p++) begin
            ia = (p == 0) ? -5 : (p == 1) ? 3 : 7;
            ib = (p == 0) ? 3 : (p == 1) ? -5 : 7;
            a  = sx(ia);
            b  = sx(ib);
            case (k)
                0:       taken = a == b;
                1:       taken = a != b;
                4:       taken = $signed(a) < $signed(b);
                5:       taken = $signed(a) >= $signed(b);
                6:       taken = a < b;
                default: taken = a >= b;
            endcase
            name = $sformatf("branch funct3=%0d pair %0d", k, p);
            newProgram();
            emit(encI(ia, 0, `F3_ADD, 1, `OP_IMM));
            emit(encI(ib, 0, `F3_ADD, 2, `OP_IMM));
            emit(encB(12, 2, 1, k[2:0]));
            emit(encI(1, 0, `F3_ADD, 3, `OP_IMM)); // fall-through marker
            emit(encJ(8, 0));
            emit(encI(1, 0, `F3_ADD, 4, `OP_IMM)); // taken marker
            expectReg(3, {63'b0, !taken});
            expectReg(4, {63'b0, taken});
            runProgram(name);
            verifyRegs(name);
        end
    end
endtask

task automatic jumpTest();
    newProgram();
    emit(encJ(8, 5));
    emit(encI(1, 0, `F3_ADD, 6, `OP_IMM));
    emit(encU(0, 7, `OP_AUIPC));
    emit(encI(13, 7, 3'b000, 8, `OP_JALR)); // odd target, bit 0 dropped
    emit(encI(1, 0, `F3_ADD, 9, `OP_IMM));
    emit(encI(1, 0, `F3_ADD, 10, `OP_IMM));
    expectReg(5, `RESET_PC + 4);
    expectReg(6, 0);
    expectReg(7, `RESET_PC + 8);
    expectReg(8, `RESET_PC + 16);
    expectReg(9, 0);
    expectReg(10, 1);
    runProgram("jump");
    verifyRegs("jump");
    checkValue("jump halt address", `RESET_PC + 24, imemAddr);
endtask

task automatic haltTest();
    newProgram();
    emit(encI(5, 0, `F3_ADD, 0, `OP_IMM));
    emit(encI(7, 0, `F3_ADD, 1, `OP_IMM));
    emit(encR(`F7_BASE, 1, 1, `F3_ADD, 0, `OP_REG));
    emit(`INST_EBREAK);
    emit(encI(9, 0, `F3_ADD, 2, `OP_IMM)); // never executed
    emit(encI(1, 0, `F3_ADD, 1, `OP_IMM));
    expectReg(0, 0);
    expectReg(1, 7);
    expectReg(2, 0);
    runProgram("halt");
    repeat (10) begin
        @(negedge clk);
        checkValue("halt address hold", `RESET_PC + 12, imemAddr);
        checkValue("halt flag hold", 1, {63'b0, halted});
    end
    verifyRegs("halt");
endtask

`endif

//--- dv/tbCore.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module tbCore;

    logic        clk;
    logic        rstN;
    logic [63:0] imemAddr;
    logic [31:0] imemData;
    logic        halted;
    logic [4:0]  dbgAddr;
    logic [63:0] dbgData;

    logic [31:0] prog [0:63];
    int          progLen;
    logic [63:0] expRegs [0:31];
    logic        expValid [0:31];
    logic [7:0]  memModel [0:63]; // bytes at RESET_PC + 0..63
    int          seed;

    cpuTop DUT (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .halted   (halted),
        .dbgAddr  (dbgAddr),
        .dbgData  (dbgData)
    );

    function automatic logic [63:0] sx(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd,
                                         input logic [6:0] op);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] encU(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
    endfunction

    // past the loaded program everything reads as ebreak
    function automatic logic [31:0] fetchWord(input logic [63:0] addr);
        logic [63:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < 64'(progLen))
            return prog[idx[5:0]];
        else
            return `INST_EBREAK;
    endfunction

    `include "tbTasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        imemData = `INST_EBREAK;
        forever begin
            @(negedge clk);
            imemData = fetchWord(imemAddr);
        end
    end

    initial begin
        rstN    = 1'b0;
        dbgAddr = '0;
        seed    = 32'ha1d;
        progLen = 0;
        aluTest();
        mulDivTest();
        memTest();
        branchTest();
        jumpTest();
        haltTest();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
+incdir+dv
hw/rvPkg.sv
hw/immGen.sv
hw/execUnit.sv
hw/regFile.sv
hw/dataMem.sv
hw/pcUnit.sv
hw/cpuTop.sv
dv/tbCore.sv

//--- hw/cpuTop.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module cpuTop import rvPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    output logic [`XLEN-1:0]   imemAddr,
    input  logic [31:0]        imemData,
    output logic               halted,
    input  logic [4:0]         dbgAddr,
    output logic [`XLEN-1:0]   dbgData
);

    rvInst_u          inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Data, rs2Data;
    logic [`XLEN-1:0] memRdAddr, memRdData;
    logic             regWrEn, memWrEn, redirect;
    logic [4:0]       regWrAddr;
    logic [`XLEN-1:0] regWrData, memWrAddr, memWrData, redirectPc;
    logic [7:0]       memWrMask;

    assign inst     = imemData;
    assign imemAddr = pc;

    pcUnit u_pcUnit (
        .clk        (clk),
        .rstN       (rstN),
        .inst       (inst),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pc         (pc),
        .halted     (halted)
    );

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (inst.r.rs1),
        .rs2Addr (inst.r.rs2),
        .dbgAddr (dbgAddr),
        .wrAddr  (regWrAddr),
        .wrEn    (regWrEn),
        .wrData  (regWrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .dbgData (dbgData)
    );

    execUnit u_execUnit (
        .inst       (inst),
        .pc         (pc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .halted     (halted),
        .memRdData  (memRdData),
        .memRdAddr  (memRdAddr),
        .regWrEn    (regWrEn),
        .regWrAddr  (regWrAddr),
        .regWrData  (regWrData),
        .memWrEn    (memWrEn),
        .memWrAddr  (memWrAddr),
        .memWrData  (memWrData),
        .memWrMask  (memWrMask),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    dataMem u_dataMem (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddr (memRdAddr),
        .wrAddr (memWrAddr),
        .wrData (memWrData),
        .wrEn   (memWrEn),
        .wrMask (memWrMask),
        .rdData (memRdData)
    );

endmodule

//--- hw/dataMem.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module dataMem (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`XLEN-1:0]   rdAddr,
    input  logic [`XLEN-1:0]   wrAddr,
    input  logic [`XLEN-1:0]   wrData,
    input  logic               wrEn,
    input  logic [7:0]         wrMask,
    output logic [`XLEN-1:0]   rdData
);

    localparam int idxW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [idxW-1:0]  rdIdx;
    logic [idxW-1:0]  wrIdx;

    // word index from byte offset, wraps at idxW bits
    assign rdIdx = idxW'((rdAddr - `RESET_PC) >> 3);
    assign wrIdx = idxW'((wrAddr - `RESET_PC) >> 3);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wrEn) begin
            for (int b = 0; b < 8; b++) begin
                if (wrMask[b]) begin
                    mem[wrIdx][b*8 +: 8] <= wrData[b*8 +: 8];
                end
            end
        end
    end

    assign rdData = mem[rdIdx];

endmodule

//--- hw/execUnit.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module execUnit import rvPkg::*; (
    input  rvInst_u            inst,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1Data,
    input  logic [`XLEN-1:0]   rs2Data,
    input  logic               halted,
    input  logic [`XLEN-1:0]   memRdData,
    output logic [`XLEN-1:0]   memRdAddr,
    output logic               regWrEn,
    output logic [4:0]         regWrAddr,
    output logic [`XLEN-1:0]   regWrData,
    output logic               memWrEn,
    output logic [`XLEN-1:0]   memWrAddr,
    output logic [`XLEN-1:0]   memWrData,
    output logic [7:0]         memWrMask,
    output logic               redirect,
    output logic [`XLEN-1:0]   redirectPc
);

    logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [31:0]      a32, b32;
    logic [31:0]      divQ, divR, divUQ, divUR;
    logic [`XLEN-1:0] loadWord, loadVal;
    logic [7:0]       storeMask;
    logic [`XLEN-1:0] linkPc;
    logic             wrValid;
    logic [`XLEN-1:0] result;

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    immGen u_immGen (
        .inst   (inst),
        .immI   (immI),
        .immS   (immS),
        .immB   (immB),
        .immU   (immU),
        .immJ   (immJ),
        .funct3 (funct3),
        .funct7 (funct7)
    );

    assign a32    = rs1Data[31:0];
    assign b32    = rs2Data[31:0];
    assign linkPc = pc + 64'd4;

    // 32-bit divide, ISA results for zero and overflow
    always_comb begin
        if (b32 == 32'd0) begin
            divQ  = '1;
            divR  = a32;
            divUQ = '1;
            divUR = a32;
        end else begin
            divUQ = a32 / b32;
            divUR = a32 % b32;
            if (a32 == 32'h8000_0000 && b32 == 32'hffff_ffff) begin
                divQ = a32;
                divR = '0;
            end else begin
                divQ = $signed(a32) / $signed(b32);
                divR = $signed(a32) % $signed(b32);
            end
        end
    end

    // load: whole word read, shift down to lane
    assign memRdAddr = rs1Data + immI;
    assign loadWord  = memRdData >> {memRdAddr[2:0], 3'b000};

    always_comb begin
        case (funct3[1:0])
            2'd0:    loadVal = funct3[2] ? {56'b0, loadWord[7:0]}
                                         : {{56{loadWord[7]}}, loadWord[7:0]};
            2'd1:    loadVal = funct3[2] ? {48'b0, loadWord[15:0]}
                                         : {{48{loadWord[15]}}, loadWord[15:0]};
            2'd2:    loadVal = funct3[2] ? {32'b0, loadWord[31:0]} : sext32(loadWord[31:0]);
            default: loadVal = loadWord;
        endcase
    end

    // store: data and mask shifted into lane
    assign memWrAddr = rs1Data + immS;
    assign memWrData = rs2Data << {memWrAddr[2:0], 3'b000};
    assign memWrMask = storeMask << memWrAddr[2:0];
    assign memWrEn   = (inst.r.opcode == `OP_STORE) && !funct3[2] && !halted;

    always_comb begin
        case (funct3[1:0])
            2'd0:    storeMask = 8'h01;
            2'd1:    storeMask = 8'h03;
            2'd2:    storeMask = 8'h0f;
            default: storeMask = 8'hff;
        endcase
    end

    always_comb begin
        wrValid    = 1'b0;
        result     = '0;
        redirect   = 1'b0;
        redirectPc = pc + immB;
        case (inst.r.opcode)
            `OP_LUI: begin
                wrValid = 1'b1;
                result  = immU;
            end
            `OP_AUIPC: begin
                wrValid = 1'b1;
                result  = pc + immU;
            end
            `OP_JAL: begin
                wrValid    = 1'b1;
                result     = linkPc;
                redirect   = 1'b1;
                redirectPc = pc + immJ;
            end
            `OP_JALR: begin
                if (funct3 == 3'b000) begin
                    wrValid    = 1'b1;
                    result     = linkPc;
                    redirect   = 1'b1;
                    redirectPc = (rs1Data + immI) & ~64'd1;
                end
            end
            `OP_BRANCH: begin
                case (funct3)
                    `F3_BEQ:  redirect = rs1Data == rs2Data;
                    `F3_BNE:  redirect = rs1Data != rs2Data;
                    `F3_BLT:  redirect = $signed(rs1Data) < $signed(rs2Data);
                    `F3_BGE:  redirect = $signed(rs1Data) >= $signed(rs2Data);
                    `F3_BLTU: redirect = rs1Data < rs2Data;
                    `F3_BGEU: redirect = rs1Data >= rs2Data;
                    default:  redirect = 1'b0;
                endcase
            end
            `OP_LOAD: begin
                wrValid = funct3 != 3'b111;
                result  = loadVal;
            end
            `OP_IMM: begin
                wrValid = 1'b1;
                case (funct3)
                    `F3_ADD:  result = rs1Data + immI;
                    `F3_SLT:  result = {63'b0, $signed(rs1Data) < $signed(immI)};
                    `F3_SLTU: result = {63'b0, rs1Data < immI};
                    `F3_XOR:  result = rs1Data ^ immI;
                    `F3_OR:   result = rs1Data | immI;
                    `F3_AND:  result = rs1Data & immI;
                    `F3_SLL: begin
                        wrValid = {funct7[6:1], 1'b0} == `F7_BASE;
                        result  = rs1Data << immI[5:0];
                    end
                    default: begin // srli / srai, shamt[5] sits in funct7[0]
                        if ({funct7[6:1], 1'b0} == `F7_ALT)
                            result = $signed(rs1Data) >>> immI[5:0];
                        else
                            result = rs1Data >> immI[5:0];
                        wrValid = ({funct7[6:1], 1'b0} == `F7_ALT)
                               || ({funct7[6:1], 1'b0} == `F7_BASE);
                    end
                endcase
            end
            `OP_IMM32: begin
                case (funct3)
                    `F3_ADD: begin
                        wrValid = 1'b1;
                        result  = sext32(a32 + immI[31:0]);
                    end
                    `F3_SLL: begin
                        wrValid = funct7 == `F7_BASE;
                        result  = sext32(a32 << immI[4:0]);
                    end
                    `F3_SR: begin
                        wrValid = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                        if (funct7 == `F7_ALT)
                            result = sext32($signed(a32) >>> immI[4:0]);
                        else
                            result = sext32(a32 >> immI[4:0]);
                    end
                    default: wrValid = 1'b0;
                endcase
            end
            `OP_REG: begin
                case (funct7)
                    `F7_BASE: begin
                        wrValid = 1'b1;
                        case (funct3)
                            `F3_ADD:  result = rs1Data + rs2Data;
                            `F3_SLL:  result = rs1Data << rs2Data[5:0];
                            `F3_SLT:  result = {63'b0, $signed(rs1Data) < $signed(rs2Data)};
                            `F3_SLTU: result = {63'b0, rs1Data < rs2Data};
                            `F3_XOR:  result = rs1Data ^ rs2Data;
                            `F3_SR:   result = rs1Data >> rs2Data[5:0];
                            `F3_OR:   result = rs1Data | rs2Data;
                            default:  result = rs1Data & rs2Data;
                        endcase
                    end
                    `F7_ALT: begin
                        wrValid = (funct3 == `F3_ADD) || (funct3 == `F3_SR);
                        if (funct3 == `F3_ADD)
                            result = rs1Data - rs2Data;
                        else
                            result = $signed(rs1Data) >>> rs2Data[5:0];
                    end
                    `F7_MULDIV: begin
                        wrValid = funct3 == `F3_MUL; // 64-bit div/rem not supported
                        result  = rs1Data * rs2Data;
                    end
                    default: wrValid = 1'b0;
                endcase
            end
            `OP_REG32: begin
                case (funct7)
                    `F7_BASE: begin
                        wrValid = (funct3 == `F3_ADD) || (funct3 == `F3_SLL)
                               || (funct3 == `F3_SR);
                        case (funct3)
                            `F3_ADD: result = sext32(a32 + b32);
                            `F3_SLL: result = sext32(a32 << b32[4:0]);
                            default: result = sext32(a32 >> b32[4:0]);
                        endcase
                    end
                    `F7_ALT: begin
                        wrValid = (funct3 == `F3_ADD) || (funct3 == `F3_SR);
                        if (funct3 == `F3_ADD)
                            result = sext32(a32 - b32);
                        else
                            result = sext32($signed(a32) >>> b32[4:0]);
                    end
                    `F7_MULDIV: begin
                        wrValid = 1'b1;
                        case (funct3)
                            `F3_MUL:  result = sext32(a32 * b32);
                            `F3_DIV:  result = sext32(divQ);
                            `F3_DIVU: result = sext32(divUQ);
                            `F3_REM:  result = sext32(divR);
                            `F3_REMU: result = sext32(divUR);
                            default:  wrValid = 1'b0;
                        endcase
                    end
                    default: wrValid = 1'b0;
                endcase
            end
            `OP_SYSTEM: wrValid = 1'b0; // ebreak halts in pcUnit
            default:    wrValid = 1'b0;
        endcase
    end

    assign regWrAddr = inst.r.rd;
    assign regWrData = result;
    assign regWrEn   = wrValid && (inst.r.rd != 5'd0) && !halted;

endmodule

//--- hw/immGen.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module immGen import rvPkg::*; (
    input  rvInst_u            inst,
    output logic [`XLEN-1:0]   immI,
    output logic [`XLEN-1:0]   immS,
    output logic [`XLEN-1:0]   immB,
    output logic [`XLEN-1:0]   immU,
    output logic [`XLEN-1:0]   immJ,
    output logic [2:0]         funct3,
    output logic [6:0]         funct7
);

    assign immI = {{52{inst.i.imm12[11]}}, inst.i.imm12};

    assign immS = {{52{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};

    // branch offset, bit 0 always zero
    assign immB = {{51{inst.b.imm12}},
                   inst.b.imm12,
                   inst.b.imm11,
                   inst.b.imm10to5,
                   inst.b.imm4to1,
                   1'b0};

    assign immU = {{32{inst.u.imm20[19]}}, inst.u.imm20, 12'b0};

    assign immJ = {{43{inst.j.imm20}},
                   inst.j.imm20,
                   inst.j.imm19to12,
                   inst.j.imm11,
                   inst.j.imm10to1,
                   1'b0};

    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;

endmodule

//--- hw/pcUnit.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module pcUnit import rvPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  rvInst_u            inst,
    input  logic               redirect,
    input  logic [`XLEN-1:0]   redirectPc,
    output logic [`XLEN-1:0]   pc,
    output logic               halted
);

    logic isEbreak;

    assign isEbreak = inst == `INST_EBREAK;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (isEbreak) begin
                halted <= 1'b1; // pc stays on the ebreak
            end else if (redirect) begin
                pc <= redirectPc;
            end else begin
                pc <= pc + 64'd4;
            end
        end
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps
`include "rvConsts.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [4:0]         rs1Addr,
    input  logic [4:0]         rs2Addr,
    input  logic [4:0]         dbgAddr,
    input  logic [4:0]         wrAddr,
    input  logic               wrEn,
    input  logic [`XLEN-1:0]   wrData,
    output logic [`XLEN-1:0]   rs1Data,
    output logic [`XLEN-1:0]   rs2Data,
    output logic [`XLEN-1:0]   dbgData
);

    logic [`XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];
    assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];

endmodule

//--- hw/rvConsts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 64

`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_IMM32  7'b0011011
`define OP_REG    7'b0110011
`define OP_REG32  7'b0111011
`define OP_SYSTEM 7'b1110011

`define F7_BASE   7'h00
`define F7_ALT    7'h20
`define F7_MULDIV 7'h01

// alu funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// muldiv funct3
`define F3_MUL  3'b000
`define F3_DIV  3'b100
`define F3_DIVU 3'b101
`define F3_REM  3'b110
`define F3_REMU 3'b111

`define RESET_PC    64'h0000_0000_8000_0000
`define INST_EBREAK 32'h0010_0073
`define DMEM_WORDS  512

`endif

//--- hw/rvPkg.sv
package rvPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvInstR_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvInstI_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } rvInstS_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } rvInstB_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rvInstU_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rvInstJ_t;

    // one instruction word, six format views
    typedef union packed {
        rvInstR_t r;
        rvInstI_t i;
        rvInstS_t s;
        rvInstB_t b;
        rvInstU_t u;
        rvInstJ_t j;
    } rvInst_u;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module tbCore -o simCore

# keep the output even when the simulation stops with an error
simOut=$(./obj_dir/simCore || true)
echo "$simOut"

if grep -q "^TEST PASSED$" <<< "$simOut"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
